//--- logic/dram_fifo_pkg.sv
/* shared widths and types of the burst-buffered stream FIFO
   a stored word is the 64-bit stream data with tlast on top (bit 64) */

`default_nettype none

package dram_fifo_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int unsigned DATA_W = 64;          // stream tdata width
  localparam int unsigned WORD_W = DATA_W + 1;  // data plus tlast flag

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------
  typedef logic [WORD_W-1:0] word_t;            // {tlast, tdata}

  // shared by the burst writer and the burst reader
  typedef enum logic [1:0] {
    st_idle,                                    // waiting for a burst start condition
    st_burst,                                   // one word per cycle
    st_drain                                    // last read word still in flight
  } burst_state_e;

endpackage

`default_nettype wire

//--- logic/stream_buffer.sv
/* first-word-fall-through FIFO, head word is valid whenever o_count is nonzero
   pushes while full and pops while empty are ignored, DEPTH must be at least 2 */

`timescale 1ns/1ps
`default_nettype none

module stream_buffer
  import dram_fifo_pkg::*;
#(
  parameter int unsigned DEPTH = 16
) (
  input  wire logic                       ddr3_axi_clk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_push,
  input  wire word_t                      i_word,
  output logic                            o_full,
  input  wire logic                       i_pop,
  output word_t                           o_word,
  output logic [$clog2(DEPTH+1)-1:0]      o_count
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  word_t            mem [DEPTH];                // storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             wr_ok;                      // push actually taken
  logic             rd_ok;                      // pop actually taken

  assign o_full = (o_count == CNT_FULL);
  assign wr_ok  = i_push && !o_full;
  assign rd_ok  = i_pop && (o_count != '0);
  assign o_word = mem[rd_ptr];                  // fall-through head

  always_ff @(posedge ddr3_axi_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_word;
    end
  end

  // ----------------------------------------------------------
  // pointers and fill count
  // ----------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   o_count <= o_count + 1'b1;
        2'b01:   o_count <= o_count - 1'b1;
        default: o_count <= o_count;            // none, or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/burst_writer.sv
/* moves ingress words into the ring memory in bursts of BURST_LEN words
   a partial burst goes out once the ingress count holds still for FLUSH_CYCLES
   i_in_count is the ingress count widened to the memory count width */

`timescale 1ns/1ps
`default_nettype none

module burst_writer
  import dram_fifo_pkg::*;
#(
  parameter int unsigned BURST_LEN    = 8,
  parameter int unsigned FLUSH_CYCLES = 16,
  parameter int unsigned MEM_DEPTH    = 64
) (
  input  wire logic                        ddr3_axi_clk,
  input  wire logic                        i_rst_n,
  input  wire logic [$clog2(MEM_DEPTH+1)-1:0] i_in_count,
  input  wire word_t                       i_in_word,
  output logic                             o_in_pop,
  input  wire logic [$clog2(MEM_DEPTH+1)-1:0] i_mem_free,
  output logic                             o_wr_en,
  output word_t                            o_wr_word
);

  localparam int unsigned CNT_W  = $clog2(MEM_DEPTH + 1);
  localparam int unsigned LEN_W  = $clog2(BURST_LEN + 1);
  localparam int unsigned IDLE_W = $clog2(FLUSH_CYCLES + 1);
  localparam logic [CNT_W-1:0]  BURST_CNT = CNT_W'(BURST_LEN);
  localparam logic [LEN_W-1:0]  BURST_MAX = LEN_W'(BURST_LEN);
  localparam logic [IDLE_W-1:0] IDLE_MAX  = IDLE_W'(FLUSH_CYCLES);

  burst_state_e      state;
  logic [LEN_W-1:0]  burst_len;                 // latched at burst start
  logic [LEN_W-1:0]  beat_cnt;                  // words written so far
  logic [IDLE_W-1:0] idle_cnt;                  // cycles with a steady ingress count
  logic [CNT_W-1:0]  prev_count;
  logic              start_full;
  logic              start_flush;
  logic              last_beat;

  assign start_full  = (i_in_count >= BURST_CNT) && (i_mem_free >= BURST_CNT);
  assign start_flush = (i_in_count != '0) && (idle_cnt == IDLE_MAX)
                       && (i_mem_free >= i_in_count);  // partial burst must fit too
  assign last_beat   = (beat_cnt == burst_len - 1'b1);

  // pop and write in the same cycle, head word goes straight to the memory
  assign o_in_pop  = (state == st_burst) && (i_in_count != '0);
  assign o_wr_en   = o_in_pop;
  assign o_wr_word = i_in_word;

  // ----------------------------------------------------------
  // idle timer for the partial burst flush
  // ----------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      prev_count <= '0;
      idle_cnt   <= '0;
    end else begin
      prev_count <= i_in_count;
      if ((state != st_idle) || (i_in_count != prev_count) || (i_in_count == '0)) begin
        idle_cnt <= '0;                         // restart on any change
      end else if (idle_cnt != IDLE_MAX) begin
        idle_cnt <= idle_cnt + 1'b1;            // saturates at the limit
      end
    end
  end

  // ----------------------------------------------------------
  // burst FSM
  // ----------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      state     <= st_idle;
      burst_len <= '0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start_full || start_flush) begin
            // full burst wins, a flush only ever holds fewer than BURST_LEN words
            burst_len <= start_full ? BURST_MAX : LEN_W'(i_in_count);
            beat_cnt  <= '0;
            state     <= st_burst;
          end
        end
        st_burst: begin
          if (o_in_pop) begin
            if (last_beat) begin
              state <= st_idle;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= st_idle;              // writer has no drain phase
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/ring_memory.sv
/* circular word store with one write and one registered read port
   MEM_DEPTH must be a power of two, callers never write when full or read when empty */

`timescale 1ns/1ps
`default_nettype none

module ring_memory
  import dram_fifo_pkg::*;
#(
  parameter int unsigned MEM_DEPTH = 64
) (
  input  wire logic                         ddr3_axi_clk,
  input  wire logic                         i_rst_n,
  input  wire logic                         i_wr_en,
  input  wire word_t                        i_wr_word,
  output logic [$clog2(MEM_DEPTH+1)-1:0]    o_free,
  input  wire logic                         i_rd_en,
  output word_t                             o_rd_word,
  output logic                              o_rd_valid,
  output logic [$clog2(MEM_DEPTH+1)-1:0]    o_occupancy
);

  localparam int unsigned ADDR_W = $clog2(MEM_DEPTH);
  localparam int unsigned CNT_W  = $clog2(MEM_DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(MEM_DEPTH);

  word_t             mem [MEM_DEPTH];           // the "dram"
  logic [ADDR_W-1:0] wr_ptr;                    // wraps by overflow
  logic [ADDR_W-1:0] rd_ptr;

  assign o_free = CNT_FULL - o_occupancy;

  // ----------------------------------------------------------
  // array and read data
  // ----------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_wr_word;
    end
    if (i_rd_en) begin
      o_rd_word <= mem[rd_ptr];                 // one cycle read latency
    end
  end

  // ----------------------------------------------------------
  // pointers, occupancy and read strobe
  // ----------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      o_occupancy <= '0;
      o_rd_valid  <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_en;                    // matches the o_rd_word register
      if (i_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_wr_en, i_rd_en})
        2'b10:   o_occupancy <= o_occupancy + 1'b1;
        2'b01:   o_occupancy <= o_occupancy - 1'b1;
        default: o_occupancy <= o_occupancy;    // both or neither cancel out
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/burst_reader.sv
/* fetches bursts of up to BURST_LEN words from the ring memory into the egress buffer
   a burst starts only with BURST_LEN free egress slots, so no push is ever dropped */

`timescale 1ns/1ps
`default_nettype none

module burst_reader
  import dram_fifo_pkg::*;
#(
  parameter int unsigned BURST_LEN = 8,
  parameter int unsigned MEM_DEPTH = 64,
  parameter int unsigned BUF_DEPTH = 16
) (
  input  wire logic                           ddr3_axi_clk,
  input  wire logic                           i_rst_n,
  input  wire logic [$clog2(MEM_DEPTH+1)-1:0] i_occupancy,
  output logic                                o_rd_en,
  input  wire word_t                          i_rd_word,
  input  wire logic                           i_rd_valid,
  input  wire logic [$clog2(BUF_DEPTH+1)-1:0] i_out_count,
  output logic                                o_push,
  output word_t                               o_push_word
);

  localparam int unsigned OCC_W = $clog2(MEM_DEPTH + 1);
  localparam int unsigned OUT_W = $clog2(BUF_DEPTH + 1);
  localparam int unsigned LEN_W = $clog2(BURST_LEN + 1);
  localparam logic [OCC_W-1:0] BURST_OCC = OCC_W'(BURST_LEN);
  localparam logic [OUT_W-1:0] BURST_OUT = OUT_W'(BURST_LEN);
  localparam logic [OUT_W-1:0] BUF_SLOTS = OUT_W'(BUF_DEPTH);
  localparam logic [LEN_W-1:0] BURST_MAX = LEN_W'(BURST_LEN);

  burst_state_e     state;
  logic [LEN_W-1:0] burst_len;                  // min(occupancy, BURST_LEN)
  logic [LEN_W-1:0] beat_cnt;                   // reads issued so far
  logic [OUT_W-1:0] out_free;                   // egress slots left
  logic             start;
  logic             last_beat;

  assign out_free  = BUF_SLOTS - i_out_count;
  assign start     = (i_occupancy != '0) && (out_free >= BURST_OUT);
  assign last_beat = (beat_cnt == burst_len - 1'b1);
  assign o_rd_en   = (state == st_burst);

  // returned words go straight into the egress buffer
  assign o_push      = i_rd_valid;
  assign o_push_word = i_rd_word;

  // ----------------------------------------------------------
  // burst FSM
  // ----------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      state     <= st_idle;
      burst_len <= '0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            burst_len <= (i_occupancy >= BURST_OCC) ? BURST_MAX : LEN_W'(i_occupancy);
            beat_cnt  <= '0;
            state     <= st_burst;
          end
        end
        st_burst: begin
          if (last_beat) begin
            state <= st_drain;                  // last word returns next cycle
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        st_drain: begin
          state <= st_idle;                     // egress count now includes every push
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/dram_fifo_top.sv
/* single-channel stream FIFO, ingress buffer -> burst writer -> ring memory ->
   burst reader -> egress buffer, all on ddr3_axi_clk
   BURST_LEN <= BUF_DEPTH <= MEM_DEPTH, MEM_DEPTH a power of two and a multiple of BURST_LEN */

`timescale 1ns/1ps
`default_nettype none

module dram_fifo_top
  import dram_fifo_pkg::*;
#(
  parameter int unsigned BUF_DEPTH    = 16,
  parameter int unsigned MEM_DEPTH    = 64,
  parameter int unsigned BURST_LEN    = 8,
  parameter int unsigned FLUSH_CYCLES = 16
) (
  input  wire logic              ddr3_axi_clk,
  input  wire logic              i_rst_n,
  input  wire logic [DATA_W-1:0] i_tdata,
  input  wire logic              i_tlast,
  input  wire logic              i_tvalid,
  output logic                   o_i_tready,
  output logic [DATA_W-1:0]      o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  wire logic              i_o_tready
);

  localparam int unsigned BCNT_W = $clog2(BUF_DEPTH + 1);
  localparam int unsigned MCNT_W = $clog2(MEM_DEPTH + 1);

  // ----------------------------------------------------------
  // stage links
  // ----------------------------------------------------------
  word_t             in_word;                   // packed input beat
  logic              in_full;
  word_t             in_head;
  logic [BCNT_W-1:0] in_count;
  logic [MCNT_W-1:0] in_count_m;                // ingress count at memory width
  logic              in_pop;
  logic              wr_en;
  word_t             wr_word;
  logic [MCNT_W-1:0] mem_free;
  logic              rd_en;
  word_t             rd_word;
  logic              rd_valid;
  logic [MCNT_W-1:0] occupancy;
  logic              push;
  word_t             push_word;
  word_t             out_word;
  logic [BCNT_W-1:0] out_count;

  assign in_word    = {i_tlast, i_tdata};       // tlast rides in bit 64
  assign o_i_tready = !in_full;
  assign in_count_m = MCNT_W'(in_count);

  assign o_tvalid = (out_count != '0);
  assign o_tdata  = out_word[DATA_W-1:0];
  assign o_tlast  = out_word[DATA_W];

  stream_buffer #(.DEPTH(BUF_DEPTH)) u_ingress (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_push       (i_tvalid),                   // taken only when not full
    .i_word       (in_word),
    .o_full       (in_full),
    .i_pop        (in_pop),
    .o_word       (in_head),
    .o_count      (in_count)
  );

  burst_writer #(
    .BURST_LEN    (BURST_LEN),
    .FLUSH_CYCLES (FLUSH_CYCLES),
    .MEM_DEPTH    (MEM_DEPTH)
  ) u_writer (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_in_count   (in_count_m),
    .i_in_word    (in_head),
    .o_in_pop     (in_pop),
    .i_mem_free   (mem_free),
    .o_wr_en      (wr_en),
    .o_wr_word    (wr_word)
  );

  ring_memory #(.MEM_DEPTH(MEM_DEPTH)) u_memory (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_wr_en      (wr_en),
    .i_wr_word    (wr_word),
    .o_free       (mem_free),
    .i_rd_en      (rd_en),
    .o_rd_word    (rd_word),
    .o_rd_valid   (rd_valid),
    .o_occupancy  (occupancy)
  );

  burst_reader #(
    .BURST_LEN    (BURST_LEN),
    .MEM_DEPTH    (MEM_DEPTH),
    .BUF_DEPTH    (BUF_DEPTH)
  ) u_reader (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_occupancy  (occupancy),
    .o_rd_en      (rd_en),
    .i_rd_word    (rd_word),
    .i_rd_valid   (rd_valid),
    .i_out_count  (out_count),
    .o_push       (push),
    .o_push_word  (push_word)
  );

  stream_buffer #(.DEPTH(BUF_DEPTH)) u_egress (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_push       (push),
    .i_word       (push_word),
    .o_full       (),                           // reader reserves space up front
    .i_pop        (o_tvalid && i_o_tready),
    .o_word       (out_word),
    .o_count      (out_count)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/* free-running testbench clock, starts low
   PERIOD_NS should be even so both phases are whole ns */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;          // half period per phase
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_dram_fifo.sv
/* testbench for dram_fifo_top, inputs change on the falling edge, transfers sampled on rising
   a queue model of accepted words predicts every output beat, first mismatch stops the run */

`timescale 1ns/1ps
`default_nettype none

module tb_dram_fifo
  import dram_fifo_pkg::*;
();

  localparam int BUF_DEPTH    = 16;
  localparam int MEM_DEPTH    = 64;
  localparam int BURST_LEN    = 8;
  localparam int FLUSH_CYCLES = 16;
  localparam int PERIOD_NS    = 100;

  // ----------------------------------------------------------
  // test lengths and watchdog limit
  // ----------------------------------------------------------
  localparam int N_RAND       = 200;                       // steady sink
  localparam int N_SHORT      = 5;                         // below BURST_LEN, needs a flush
  localparam int N_STALL      = 300;                       // random stalls and gaps
  localparam int N_FILL       = MEM_DEPTH + 2 * BUF_DEPTH; // whole capacity
  localparam int HOLD_CYCLES  = 4 * BURST_LEN;             // ready low this long means full
  localparam int WORD_CYCLES  = 12;                        // generous bound per word
  localparam int LIMIT_CYCLES = (N_RAND + N_SHORT + N_STALL + 2 * N_FILL) * WORD_CYCLES
                                + 4 * FLUSH_CYCLES + HOLD_CYCLES;

  localparam int SINK_READY  = 0;
  localparam int SINK_HOLD   = 1;
  localparam int SINK_RANDOM = 2;

  logic              ddr3_axi_clk;
  logic              i_rst_n;
  logic [DATA_W-1:0] i_tdata;
  logic              i_tlast;
  logic              i_tvalid;
  logic              o_i_tready;
  logic [DATA_W-1:0] o_tdata;
  logic              o_tlast;
  logic              o_tvalid;
  logic              i_o_tready;

  word_t ref_q[$];                              // accepted words, oldest first
  int    n_in      = 0;                         // input transfers seen
  int    n_out     = 0;                         // output transfers seen
  int    sink_mode = SINK_READY;
  string test_name = "reset";

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) u_clock (.o_clk(ddr3_axi_clk));

  dram_fifo_top #(
    .BUF_DEPTH    (BUF_DEPTH),
    .MEM_DEPTH    (MEM_DEPTH),
    .BURST_LEN    (BURST_LEN),
    .FLUSH_CYCLES (FLUSH_CYCLES)
  ) UUT (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_tdata      (i_tdata),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_i_tready   (o_i_tready),
    .o_tdata      (o_tdata),
    .o_tlast      (o_tlast),
    .o_tvalid     (o_tvalid),
    .i_o_tready   (i_o_tready)
  );

  // ----------------------------------------------------------
  // reference model, checks and failure reports
  // ----------------------------------------------------------
  function automatic void record_accepted(input word_t w);
    ref_q.push_back(w);                         // in order of acceptance
  endfunction

  function automatic word_t next_expected();
    next_expected = ref_q.pop_front();          // FIFO order, nothing reordered
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "%s", msg);
  endtask

  // ----------------------------------------------------------
  // stimulus helpers, all driving on the falling edge
  // ----------------------------------------------------------
  task automatic drive_random_word();
    i_tdata  = {$urandom, $urandom};
    i_tlast  = ($urandom_range(5) == 0);
    i_tvalid = 1'b1;
  endtask

  task automatic send_word(input logic [DATA_W-1:0] data, input logic last, input logic gaps);
    if (gaps && ($urandom_range(3) == 0)) begin
      @(negedge ddr3_axi_clk);
      i_tvalid = 1'b0;                          // one idle beat
    end
    @(negedge ddr3_axi_clk);
    i_tdata  = data;
    i_tlast  = last;
    i_tvalid = 1'b1;
    while (!o_i_tready) begin
      @(negedge ddr3_axi_clk);                  // ready only moves on the rising edge
    end
  endtask

  task automatic send_packets(input int n, input logic gaps);
    logic last;
    for (int i = 0; i < n; i++) begin
      last = (i == n - 1) || ($urandom_range(5) == 0);  // packet ends at random
      send_word({$urandom, $urandom}, last, gaps);
    end
    @(negedge ddr3_axi_clk);
    i_tvalid = 1'b0;                            // last word went in at the edge before
  endtask

  task automatic set_sink(input int mode);
    @(posedge ddr3_axi_clk);
    sink_mode = mode;                           // takes effect at the next falling edge
  endtask

  task automatic wait_drained();
    while (n_out != n_in) begin
      @(negedge ddr3_axi_clk);
    end
  endtask

  // output ready, one driver for all modes
  initial begin
    i_o_tready = 1'b0;
    forever begin
      @(negedge ddr3_axi_clk);
      case (sink_mode)
        SINK_READY:  i_o_tready = 1'b1;
        SINK_RANDOM: i_o_tready = ($urandom_range(2) != 0);  // about 2 of 3 cycles
        default:     i_o_tready = 1'b0;
      endcase
    end
  end

  // ----------------------------------------------------------
  // compare process, both stream ports on the rising edge
  // ----------------------------------------------------------
  always @(posedge ddr3_axi_clk) begin
    if (i_rst_n) begin
      if (o_tvalid && i_o_tready) begin
        if (ref_q.size() == 0) begin
          report_failure($sformatf("%s: output word with no accepted input left", test_name));
        end else begin
          check_value(test_name, next_expected(), {o_tlast, o_tdata});
        end
        n_out++;
      end
      if (i_tvalid && o_i_tready) begin
        record_accepted({i_tlast, i_tdata});
        n_in++;
      end
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge ddr3_axi_clk);
    report_failure($sformatf("watchdog: output stalled in %s, %0d of %0d words came out",
                             test_name, n_out, n_in));
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    int unsigned seed_ret;
    int          fill_cnt;
    int          low_run;
    logic        took;
    seed_ret = $urandom(32'h84b4);
    i_rst_n  = 1'b0;
    i_tdata  = '0;
    i_tlast  = 1'b0;
    i_tvalid = 1'b0;
    repeat (3) @(negedge ddr3_axi_clk);         // three rising edges in reset
    i_rst_n = 1'b1;
    check_value("reset_tvalid", word_t'(0), word_t'(o_tvalid));
    check_value("reset_tready", word_t'(1), word_t'(o_i_tready));

    test_name = "random_packets";
    send_packets(N_RAND, 1'b0);
    wait_drained();

    test_name = "short_flush";                  // only the idle flush can move these
    send_packets(N_SHORT, 1'b0);
    wait_drained();

    test_name = "stalls_gaps";
    set_sink(SINK_RANDOM);
    send_packets(N_STALL, 1'b1);
    set_sink(SINK_READY);
    wait_drained();

    // back-pressure all the way to the input
    test_name = "fill_drain";
    set_sink(SINK_HOLD);
    fill_cnt  = 0;
    low_run   = 0;
    @(negedge ddr3_axi_clk);
    drive_random_word();
    while (low_run < HOLD_CYCLES) begin
      took = o_i_tready;                        // word goes in at the coming edge
      @(negedge ddr3_axi_clk);
      if (took) begin
        fill_cnt++;
        low_run = 0;
        drive_random_word();
      end else begin
        low_run++;
      end
    end
    i_tvalid = 1'b0;                            // pending word was never taken
    check_value("fill_min_depth", word_t'(1), word_t'(fill_cnt >= MEM_DEPTH));
    set_sink(SINK_READY);
    wait_drained();

    repeat (2 * FLUSH_CYCLES) @(negedge ddr3_axi_clk);  // nothing extra may come out
    if ((ref_q.size() == 0) && (n_out == n_in)) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("%0d accepted words never came out", n_in - n_out);
      $display("ERRORS FOUND");
      $fatal(1, "words left in the reference queue");
    end
  end

endmodule

`default_nettype wire

//--- all.f
logic/dram_fifo_pkg.sv
logic/stream_buffer.sv
logic/burst_writer.sv
logic/ring_memory.sv
logic/burst_reader.sv
logic/dram_fifo_top.sv
testbench/tb_clock_gen.sv
testbench/tb_dram_fifo.sv

//--- Makefile
# Verilator flow for the burst-buffered stream FIFO
# any variable below can be overridden, e.g. make BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dram_fifo
RTL_TOP   ?= dram_fifo_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
